/* Bender.yml */
package:
  name: cache_sim

sources:
  - include_dirs:
      - common
    files:
      - common/cache_sim_pkg.sv
      - design/cmd_decoder.sv
      - cache_way/cache_way.sv
      - design/way_select.sv
      - design/cache_sim.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/cache_sim_tb.sv

/* cache_sim.f */
+incdir+common
common/cache_sim_pkg.sv
design/cmd_decoder.sv
cache_way/cache_way.sv
design/way_select.sv
design/cache_sim.sv
tests/cache_sim_tb.sv

/* cache_way/cache_way.sv */
// one cache way: tag, MESI state and LRU age per set, with tag compare and broadcast update
`timescale 1ns/1ps
`default_nettype none

`include "cache_sim_cfg.svh"

module cache_way #(
    parameter int WAY_ID = 0
) (
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire logic            st_valid_i,
    input  cache_sim_pkg::cmd_e  st_cmd_i,
    input  cache_sim_pkg::tag_t  st_tag_i,
    input  cache_sim_pkg::set_t  st_set_i,
    input  wire logic            upd_en_i,
    input  cache_sim_pkg::way_t  upd_way_i,
    input  cache_sim_pkg::age_t  upd_age_ref_i,
    input  cache_sim_pkg::tag_t  upd_tag_i,
    input  cache_sim_pkg::mesi_e upd_mesi_i,
    output logic                 hit_o,
    output cache_sim_pkg::age_t  age_o,
    output cache_sim_pkg::mesi_e mesi_o
);

    // per-set storage of this way
    cache_sim_pkg::tag_t  tag_mem  [`CACHE_SETS];
    cache_sim_pkg::mesi_e mesi_mem [`CACHE_SETS];
    cache_sim_pkg::age_t  age_mem  [`CACHE_SETS];

    logic own_upd;
    logic do_clear;
    logic aging;

    assign own_upd  = upd_en_i && (upd_way_i == cache_sim_pkg::way_t'(WAY_ID));
    assign do_clear = st_valid_i && (st_cmd_i == cache_sim_pkg::CMD_CLEAR);

    // an invalidate leaves the ages alone
    assign aging = (st_cmd_i != cache_sim_pkg::CMD_INVAL);

    // lookup for the set in stage 1
    assign hit_o = st_valid_i
                && (mesi_mem[st_set_i] != cache_sim_pkg::INVALID)
                && (tag_mem[st_set_i] == st_tag_i);
    assign age_o  = age_mem[st_set_i];
    assign mesi_o = mesi_mem[st_set_i];

    // state and age, cleared by reset or clear-all
    always_ff @(posedge clk) begin
        if (reset_i || do_clear) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                mesi_mem[s] <= cache_sim_pkg::INVALID;
                age_mem[s]  <= cache_sim_pkg::age_t'(WAY_ID);  // way k starts at age k
            end
        end else if (own_upd) begin
            mesi_mem[st_set_i] <= upd_mesi_i;
            if (aging) begin
                age_mem[st_set_i] <= '0;    // now most recently used
            end
        end else if (upd_en_i && aging) begin
            // younger than the chosen way moves one step older
            if (age_mem[st_set_i] < upd_age_ref_i) begin
                age_mem[st_set_i] <= age_mem[st_set_i] + 1'b1;
            end
        end
    end

    // tag storage
    always_ff @(posedge clk) begin
        if (own_upd) begin
            tag_mem[st_set_i] <= upd_tag_i;
        end
    end

endmodule

`default_nettype wire

/* common/cache_sim_cfg.svh */
// cache model geometry: way and set counts plus the address field widths
`ifndef CACHE_SIM_CFG_SVH
`define CACHE_SIM_CFG_SVH

// associativity, 4 gives the instruction cache variant
`define CACHE_WAYS 8
`define CACHE_SETS 16

// address split into tag and set index
`define ADDR_BITS 16
`define SET_BITS 4
`define TAG_BITS (`ADDR_BITS - `SET_BITS)

// way index and LRU age share this width
`define WAY_BITS 3

`endif

/* common/cache_sim_pkg.sv */
// shared types of the cache model: address fields, way number, LRU age, MESI and command
`default_nettype none

`include "cache_sim_cfg.svh"

package cache_sim_pkg;

    typedef logic [`TAG_BITS-1:0] tag_t;   // upper address bits
    typedef logic [`SET_BITS-1:0] set_t;   // lower address bits
    typedef logic [`WAY_BITS-1:0] way_t;

    // 0 is most recently used, CACHE_WAYS-1 is the oldest
    typedef logic [`WAY_BITS-1:0] age_t;

    typedef enum logic [1:0] {
        INVALID   = 2'd0,
        SHARED    = 2'd1,
        EXCLUSIVE = 2'd2,
        MODIFIED  = 2'd3
    } mesi_e;

    // snoop invalidate and clear-all next to the two cpu accesses
    typedef enum logic [1:0] {
        CMD_READ  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_INVAL = 2'd2,
        CMD_CLEAR = 2'd3
    } cmd_e;

endpackage

`default_nettype wire

/* design/cache_sim.sv */
// set-associative data cache model: decoder, one block per way and the way selector
`timescale 1ns/1ps
`default_nettype none

`include "cache_sim_cfg.svh"

module cache_sim (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  cmd_valid_i,
    input  cache_sim_pkg::cmd_e        cmd_i,
    input  wire logic [`ADDR_BITS-1:0] addr_i,
    output logic                       res_valid_o,
    output logic                       hit_o,
    output cache_sim_pkg::way_t        way_o,
    output cache_sim_pkg::mesi_e       mesi_o,
    output logic                       evict_o
);

    // stage 1 command
    logic                 st_valid;
    cache_sim_pkg::cmd_e  st_cmd;
    cache_sim_pkg::tag_t  st_tag;
    cache_sim_pkg::set_t  st_set;

    // lookup results of every way
    logic [`CACHE_WAYS-1:0] way_hit;
    cache_sim_pkg::age_t    way_age  [`CACHE_WAYS];
    cache_sim_pkg::mesi_e   way_mesi [`CACHE_WAYS];

    // update broadcast back to the ways
    logic                 upd_en;
    cache_sim_pkg::way_t  upd_way;
    cache_sim_pkg::age_t  upd_age_ref;
    cache_sim_pkg::tag_t  upd_tag;
    cache_sim_pkg::mesi_e upd_mesi;

    cmd_decoder i_cmd_decoder (
        .clk         (clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .addr_i      (addr_i),
        .st_valid_o  (st_valid),
        .st_cmd_o    (st_cmd),
        .st_tag_o    (st_tag),
        .st_set_o    (st_set)
    );

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        cache_way #(
            .WAY_ID (w)
        ) i_cache_way (
            .clk           (clk),
            .reset_i       (reset_i),
            .st_valid_i    (st_valid),
            .st_cmd_i      (st_cmd),
            .st_tag_i      (st_tag),
            .st_set_i      (st_set),
            .upd_en_i      (upd_en),
            .upd_way_i     (upd_way),
            .upd_age_ref_i (upd_age_ref),
            .upd_tag_i     (upd_tag),
            .upd_mesi_i    (upd_mesi),
            .hit_o         (way_hit[w]),
            .age_o         (way_age[w]),
            .mesi_o        (way_mesi[w])
        );
    end

    way_select i_way_select (
        .clk           (clk),
        .reset_i       (reset_i),
        .st_valid_i    (st_valid),
        .st_cmd_i      (st_cmd),
        .st_tag_i      (st_tag),
        .hit_i         (way_hit),
        .age_i         (way_age),
        .mesi_i        (way_mesi),
        .upd_en_o      (upd_en),
        .upd_way_o     (upd_way),
        .upd_age_ref_o (upd_age_ref),
        .upd_tag_o     (upd_tag),
        .upd_mesi_o    (upd_mesi),
        .res_valid_o   (res_valid_o),
        .hit_o         (hit_o),
        .way_o         (way_o),
        .mesi_o        (mesi_o),
        .evict_o       (evict_o)
    );

endmodule

`default_nettype wire

/* design/cmd_decoder.sv */
// command decoder: stage-1 register for the command strobe and tag/set split of the address
`timescale 1ns/1ps
`default_nettype none

`include "cache_sim_cfg.svh"

module cmd_decoder (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire logic                      cmd_valid_i,
    input  cache_sim_pkg::cmd_e            cmd_i,
    input  wire logic [`ADDR_BITS-1:0]     addr_i,
    output logic                           st_valid_o,
    output cache_sim_pkg::cmd_e            st_cmd_o,
    output cache_sim_pkg::tag_t            st_tag_o,
    output cache_sim_pkg::set_t            st_set_o
);

    logic                  valid_q;
    cache_sim_pkg::cmd_e   cmd_q;
    logic [`ADDR_BITS-1:0] addr_q;

    // valid bit of stage 1
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cmd_valid_i;
        end
    end

    // command and address only move when a new command arrives
    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            cmd_q  <= cmd_i;
            addr_q <= addr_i;
        end
    end

    assign st_valid_o = valid_q;
    assign st_cmd_o   = cmd_q;

    // tag is everything above the set index
    assign st_tag_o = addr_q[`ADDR_BITS-1:`SET_BITS];
    assign st_set_o = addr_q[`SET_BITS-1:0];    // low bits pick the set

endmodule

`default_nettype wire

/* design/way_select.sv */
// way selector: hit encode, victim search, next MESI state and the registered result
`timescale 1ns/1ps
`default_nettype none

`include "cache_sim_cfg.svh"

module way_select (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    st_valid_i,
    input  cache_sim_pkg::cmd_e          st_cmd_i,
    input  cache_sim_pkg::tag_t          st_tag_i,
    input  wire logic [`CACHE_WAYS-1:0]  hit_i,
    input  cache_sim_pkg::age_t          age_i  [`CACHE_WAYS],
    input  cache_sim_pkg::mesi_e         mesi_i [`CACHE_WAYS],
    output logic                         upd_en_o,
    output cache_sim_pkg::way_t          upd_way_o,
    output cache_sim_pkg::age_t          upd_age_ref_o,
    output cache_sim_pkg::tag_t          upd_tag_o,
    output cache_sim_pkg::mesi_e         upd_mesi_o,
    output logic                         res_valid_o,
    output logic                         hit_o,
    output cache_sim_pkg::way_t          way_o,
    output cache_sim_pkg::mesi_e         mesi_o,
    output logic                         evict_o
);

    logic                 hit_any;
    logic                 inv_found;
    cache_sim_pkg::way_t  hit_way;
    cache_sim_pkg::way_t  inv_way;
    cache_sim_pkg::way_t  old_way;
    cache_sim_pkg::way_t  sel_way;
    cache_sim_pkg::mesi_e sel_mesi;
    logic                 res_hit;
    logic                 res_evict;

    // hit encode and victim search
    always_comb begin
        hit_way   = '0;
        inv_way   = '0;
        old_way   = '0;
        inv_found = 1'b0;
        // walk downwards so the lowest matching way is kept
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (hit_i[w]) begin
                hit_way = cache_sim_pkg::way_t'(w);
            end
            if (mesi_i[w] == cache_sim_pkg::INVALID) begin
                inv_found = 1'b1;
                inv_way   = cache_sim_pkg::way_t'(w);
            end
            if (age_i[w] == cache_sim_pkg::age_t'(`CACHE_WAYS - 1)) begin
                old_way = cache_sim_pkg::way_t'(w);     // LRU way
            end
        end
    end

    assign hit_any  = |hit_i;
    assign sel_way  = hit_any ? hit_way : (inv_found ? inv_way : old_way);
    assign sel_mesi = mesi_i[sel_way];

    // update request and next MESI state
    always_comb begin
        upd_en_o   = 1'b0;
        upd_mesi_o = sel_mesi;
        res_hit    = hit_any;
        res_evict  = 1'b0;
        case (st_cmd_i)
            cache_sim_pkg::CMD_READ: begin
                upd_en_o   = st_valid_i;
                upd_mesi_o = hit_any ? sel_mesi : cache_sim_pkg::EXCLUSIVE;
                res_evict  = !hit_any && (sel_mesi == cache_sim_pkg::MODIFIED);
            end
            cache_sim_pkg::CMD_WRITE: begin
                upd_en_o   = st_valid_i;
                upd_mesi_o = cache_sim_pkg::MODIFIED;
                res_evict  = !hit_any && (sel_mesi == cache_sim_pkg::MODIFIED);
            end
            cache_sim_pkg::CMD_INVAL: begin
                upd_en_o   = st_valid_i && hit_any;   // snoop miss changes nothing
                upd_mesi_o = cache_sim_pkg::INVALID;
            end
            default: begin
                res_hit = 1'b0;     // clear-all is handled inside the ways
            end
        endcase
    end

    assign upd_way_o     = sel_way;
    assign upd_age_ref_o = age_i[sel_way];
    assign upd_tag_o     = st_tag_i;

    // result stage
    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= st_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (st_valid_i) begin
            hit_o   <= res_hit;
            way_o   <= sel_way;
            mesi_o  <= sel_mesi;    // state before the update
            evict_o <= res_evict;
        end
    end

endmodule

`default_nettype wire

/* tests/cache_sim_patterns.txt */
# op addr hit way mesi evict, all hex; op R read, W write, V invalidate, C clear, - idle cycle
# mesi 0 invalid 1 shared 2 exclusive 3 modified; a clear line only defines hit
R 0010 0 0 0 0
R 0020 0 1 0 0
R 0030 0 2 0 0
R 0040 0 3 0 0
R 0050 0 4 0 0
R 0060 0 5 0 0
R 0070 0 6 0 0
R 0080 0 7 0 0
R 0030 1 2 2 0
-
R 0010 1 0 2 0
R 0090 0 1 2 0
R 0020 0 3 2 0
W 0050 1 4 2 0
-
R 0060 1 5 2 0
R 0070 1 6 2 0
R 0080 1 7 2 0
R 0030 1 2 2 0
R 0010 1 0 2 0
R 0090 1 1 2 0
R 0020 1 3 2 0
R 00a0 0 4 3 1
-
V 0080 1 7 2 0
V 00b0 0 7 0 0
R 00c0 0 7 0 0
R 0070 1 6 2 0
W 00d0 0 5 2 0
R 00d0 1 5 3 0
-
R 0015 0 0 0 0
R 0025 0 1 0 0
R 0070 1 6 2 0
R 0015 1 0 2 0
R 0075 0 2 0 0
-
C 0000 0 0 0 0
R 00d0 0 0 0 0
R 0015 0 0 0 0
R 00d0 1 0 2 0

/* tests/cache_sim_tb.sv */
// testbench of the cache model that reads command patterns, drives them and checks every result
`timescale 1ns/1ps
`default_nettype none

`include "cache_sim_cfg.svh"

module cache_sim_tb;

    logic                  clk = 1'b0;
    logic                  reset_i;
    logic                  cmd_valid_i;
    cache_sim_pkg::cmd_e   cmd_i;
    logic [`ADDR_BITS-1:0] addr_i;
    logic                  res_valid_o;
    logic                  hit_o;
    cache_sim_pkg::way_t   way_o;
    cache_sim_pkg::mesi_e  mesi_o;
    logic                  evict_o;

    // pattern lines as read from the file where op '-' marks an idle cycle
    byte                   line_op    [$];
    logic [`ADDR_BITS-1:0] line_addr  [$];
    logic [31:0]           line_hit   [$];
    logic [31:0]           line_way   [$];
    logic [31:0]           line_mesi  [$];
    logic [31:0]           line_evict [$];

    // expectations of the commands in flight
    logic [31:0] exp_hit_q   [$];
    logic [31:0] exp_way_q   [$];
    logic [31:0] exp_mesi_q  [$];
    logic [31:0] exp_evict_q [$];
    logic [31:0] due_q       [$];   // cycle where the result must show up
    bit          full_q      [$];   // clear results only define hit

    logic [31:0] e_hit;
    logic [31:0] e_way;
    logic [31:0] e_mesi;
    logic [31:0] e_evict;
    logic [31:0] e_due;
    bit          e_full;

    int cyc = 0;
    bit loaded = 1'b0;

    cache_sim i_cache_sim (
        .clk         (clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .addr_i      (addr_i),
        .res_valid_o (res_valid_o),
        .hit_o       (hit_o),
        .way_o       (way_o),
        .mesi_o      (mesi_o),
        .evict_o     (evict_o)
    );

    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h exp %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic read_patterns();
        int          fd;
        int          n;
        byte         op;
        string       line;
        logic [31:0] addr;
        logic [31:0] hit;
        logic [31:0] way;
        logic [31:0] mesi;
        logic [31:0] evict;
        fd = $fopen("tests/cache_sim_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file tests/cache_sim_patterns.txt");
            $display("Test FAILED");
            $fatal(1, "no patterns");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() == 0) continue;
            op = line.getc(0);
            if (op == "#" || op == "\n" || op == "\r") continue;    // comment or blank
            addr  = '0;
            hit   = '0;
            way   = '0;
            mesi  = '0;
            evict = '0;
            if (op != "-") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                            addr, hit, way, mesi, evict);
                if (n != 5 || !(op == "R" || op == "W" || op == "V" || op == "C")) begin
                    $display("malformed pattern line: %s", line);
                    $display("Test FAILED");
                    $fatal(1, "bad pattern file");
                end
            end
            line_op.push_back(op);
            line_addr.push_back(addr[`ADDR_BITS-1:0]);
            line_hit.push_back(hit);
            line_way.push_back(way);
            line_mesi.push_back(mesi);
            line_evict.push_back(evict);
        end
        $fclose(fd);
    endtask

    function automatic cache_sim_pkg::cmd_e op_to_cmd(input byte op);
        case (op)
            "W":     return cache_sim_pkg::CMD_WRITE;
            "V":     return cache_sim_pkg::CMD_INVAL;
            "C":     return cache_sim_pkg::CMD_CLEAR;
            default: return cache_sim_pkg::CMD_READ;
        endcase
    endfunction

    // one pattern line per falling edge
    task automatic drive_line(input int i);
        @(negedge clk);
        if (line_op[i] == "-") begin
            cmd_valid_i = 1'b0;
        end else begin
            cmd_valid_i = 1'b1;
            cmd_i       = op_to_cmd(line_op[i]);
            addr_i      = line_addr[i];
            exp_hit_q.push_back(line_hit[i]);
            exp_way_q.push_back(line_way[i]);
            exp_mesi_q.push_back(line_mesi[i]);
            exp_evict_q.push_back(line_evict[i]);
            due_q.push_back(cyc + 2);   // capture edge plus the result edge
            full_q.push_back(line_op[i] != "C");
        end
    endtask

    // each result pulse pops the oldest expectation
    always @(negedge clk) begin
        if (res_valid_o === 1'b1) begin
            if (due_q.size() == 0) begin
                $display("res_valid_o pulsed while no command was in flight");
                $display("Test FAILED");
                $fatal(1, "unexpected result");
            end else begin
                e_hit   = exp_hit_q.pop_front();
                e_way   = exp_way_q.pop_front();
                e_mesi  = exp_mesi_q.pop_front();
                e_evict = exp_evict_q.pop_front();
                e_due   = due_q.pop_front();
                e_full  = full_q.pop_front();
                check_value("res_valid_o cycle", cyc, e_due);
                check_value("hit_o", hit_o, e_hit);
                if (e_full) begin
                    check_value("way_o", way_o, e_way);
                    check_value("mesi_o", mesi_o, e_mesi);
                    check_value("evict_o", evict_o, e_evict);
                end
            end
        end
    end

    initial begin
        reset_i     = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_i       = cache_sim_pkg::CMD_READ;
        addr_i      = '0;
        read_patterns();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        for (int i = 0; i < line_op.size(); i++) begin
            drive_line(i);
        end
        @(negedge clk);
        cmd_valid_i = 1'b0;
        while (due_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);  // room for a stray pulse
        $display("Test OK");
        $finish;
    end

    // watchdog sized from the pattern count
    initial begin
        wait (loaded);
        repeat (line_op.size() * 10 + 50) @(posedge clk);
        $display("watchdog expired before all results arrived");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
